//--- rtl/cpu_pkg.sv
// CPU package with instruction field layout, opcodes and core FSM states
package cpu_pkg;

  localparam int WORD_W     = 32;
  localparam int OPCODE_W   = 4;
  localparam int REG_ADDR_W = 3;
  localparam int IMM_W      = 16;
  localparam int NUM_REGS   = 8;

  localparam int OPCODE_LSB = 28;  // Bits 31:28
  localparam int RD_LSB     = 25;  // Bits 27:25
  localparam int RS1_LSB    = 22;  // Bits 24:22
  localparam int RS2_LSB    = 19;  // Bits 21:19

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  typedef enum logic [OPCODE_W-1:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_ADDI = 4'd5,
    OP_LUI  = 4'd6,
    OP_LW   = 4'd7,
    OP_SW   = 4'd8,
    OP_BEQ  = 4'd9,
    OP_JMP  = 4'd10,
    OP_HALT = 4'd11
  } opcode_t;

  typedef enum logic [2:0] {
    FETCH, DECODE, EXECUTE, MEM, WRITEBACK, HALTED
  } core_state_t;

endpackage

//--- rtl/bus_pkg.sv
// Byte-serial bus package with frame phases and request flag positions
package bus_pkg;

  // One frame is latch, four output phases, four input phases
  typedef enum logic [3:0] {
    PH_LATCH = 4'd0,
    PH_OUT0  = 4'd1,
    PH_OUT1  = 4'd2,
    PH_OUT2  = 4'd3,
    PH_OUT3  = 4'd4,
    PH_IN0   = 4'd5,
    PH_IN1   = 4'd6,
    PH_IN2   = 4'd7,
    PH_IN3   = 4'd8
  } bus_phase_t;

  localparam int FRAME_LEN = 9;

  localparam int REQ_VALID_BIT = 31;  // Set when the frame carries a request
  localparam int REQ_WRITE_BIT = 30;  // Set for stores

endpackage

//--- rtl/cpu_alu.sv
// Combinational ALU for the CPU core, operation chosen by opcode
`timescale 1ns/1ns

module cpu_alu (
  input  cpu_pkg::opcode_t op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  output cpu_pkg::word_t   result,
  output logic             equal
);
  import cpu_pkg::*;

  always_comb begin
    case (op)
      OP_SUB:  result = a - b;
      OP_AND:  result = a & b;
      OP_OR:   result = a | b;
      OP_XOR:  result = a ^ b;
      OP_LUI:  result = b;              // Operand already shifted up
      default: result = a + b;          // ADD, ADDI and load/store address
    endcase
  end

  assign equal = (a == b);  // BEQ compare

endmodule

//--- rtl/cpu_regfile.sv
// Eight-entry register file, two read ports, one write port, r0 tied to zero
`timescale 1ns/1ns

module cpu_regfile (
  input  logic               clk,
  input  logic               arst_n,
  input  cpu_pkg::reg_addr_t rs1_addr,
  input  cpu_pkg::reg_addr_t rs2_addr,
  output cpu_pkg::word_t     rs1_data,
  output cpu_pkg::word_t     rs2_data,
  input  logic               we,
  input  cpu_pkg::reg_addr_t rd_addr,
  input  cpu_pkg::word_t     rd_data
);
  import cpu_pkg::*;

  word_t regs [1:NUM_REGS-1];  // No storage for r0

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;  // Writes to r0 are dropped
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- rtl/cpu_core.sv
// Multi-cycle CPU core, fetch to writeback FSM with a level memory request
`timescale 1ns/1ns

module cpu_core #(
  parameter cpu_pkg::word_t RESET_PC = '0
) (
  input  logic           clk,
  input  logic           arst_n,
  output logic           mem_req,
  output logic           mem_write,
  output cpu_pkg::word_t mem_addr,
  output cpu_pkg::word_t mem_wdata,
  input  logic           mem_done,
  input  cpu_pkg::word_t mem_rdata
);
  import cpu_pkg::*;

  core_state_t      state;
  word_t            pc;
  word_t            ir;
  opcode_t          op_q;
  reg_addr_t        rd_q;
  word_t            rs1_q;
  word_t            rs2_q;
  word_t            imm_q;
  word_t            res_q;
  logic             eq_q;

  opcode_t          dec_op;
  reg_addr_t        dec_rs1;
  reg_addr_t        dec_rs2;
  logic [IMM_W-1:0] dec_imm;
  word_t            imm_sext;
  word_t            rf_rs1_data;
  word_t            rf_rs2_data;
  word_t            alu_b;
  word_t            alu_result;
  logic             alu_equal;
  logic             use_imm;
  logic             rf_we;
  word_t            pc_plus4;

  // Instruction fields
  assign dec_op   = opcode_t'(ir[OPCODE_LSB +: OPCODE_W]);
  assign dec_rs1  = ir[RS1_LSB +: REG_ADDR_W];
  assign dec_rs2  = ir[RS2_LSB +: REG_ADDR_W];
  assign dec_imm  = ir[IMM_W-1:0];
  assign imm_sext = {{(WORD_W-IMM_W){dec_imm[IMM_W-1]}}, dec_imm};

  cpu_regfile u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (dec_rs1),
    .rs2_addr (dec_rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .we       (rf_we),
    .rd_addr  (rd_q),
    .rd_data  (res_q)
  );

  assign use_imm = (op_q == OP_ADDI) || (op_q == OP_LUI) ||
                   (op_q == OP_LW)   || (op_q == OP_SW);
  assign alu_b   = use_imm ? imm_q : rs2_q;

  cpu_alu u_alu (
    .op     (op_q),
    .a      (rs1_q),
    .b      (alu_b),
    .result (alu_result),
    .equal  (alu_equal)
  );

  assign rf_we = (state == WRITEBACK) &&
                 (op_q inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                               OP_ADDI, OP_LUI, OP_LW});

  assign pc_plus4 = pc + 32'd4;

  // Core addresses are bytes, the bus carries word indices
  assign mem_addr  = (state == MEM) ? word_t'(res_q[WORD_W-1:2]) : word_t'(pc[WORD_W-1:2]);
  assign mem_write = (state == MEM) && (op_q == OP_SW);
  assign mem_wdata = rs2_q;  // Store data from rs2

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= FETCH;
      pc      <= RESET_PC;
      mem_req <= 1'b0;
    end else begin
      case (state)
        FETCH: begin
          if (mem_done) begin
            mem_req <= 1'b0;
            ir      <= mem_rdata;
            state   <= DECODE;
          end else begin
            mem_req <= 1'b1;  // Held until done
          end
        end
        DECODE: begin
          op_q  <= dec_op;
          rd_q  <= ir[RD_LSB +: REG_ADDR_W];
          rs1_q <= rf_rs1_data;
          rs2_q <= rf_rs2_data;
          imm_q <= (dec_op == OP_LUI) ? {dec_imm, {(WORD_W-IMM_W){1'b0}}} : imm_sext;
          state <= (dec_op == OP_HALT) ? HALTED : EXECUTE;
        end
        EXECUTE: begin
          res_q <= alu_result;
          eq_q  <= alu_equal;
          state <= ((op_q == OP_LW) || (op_q == OP_SW)) ? MEM : WRITEBACK;
        end
        MEM: begin
          if (mem_done) begin
            mem_req <= 1'b0;
            if (op_q == OP_LW) begin
              res_q <= mem_rdata;  // Loaded word goes to writeback
            end
            state <= WRITEBACK;
          end else begin
            mem_req <= 1'b1;
          end
        end
        WRITEBACK: begin
          case (op_q)
            OP_BEQ:  pc <= eq_q ? pc_plus4 + {imm_q[WORD_W-3:0], 2'b00} : pc_plus4;
            OP_JMP:  pc <= word_t'({imm_q[IMM_W-1:0], 2'b00});  // Absolute word target
            default: pc <= pc_plus4;
          endcase
          state <= FETCH;
        end
        HALTED: begin
          mem_req <= 1'b0;  // Parked for good
        end
        default: begin
          state <= FETCH;
        end
      endcase
    end
  end

endmodule

//--- rtl/byte_bus_handler.sv
// Nine-phase byte-serial bus engine between the core and the 8-bit chip pins
`timescale 1ns/1ns

module byte_bus_handler (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           mem_req,
  input  logic           mem_write,
  input  cpu_pkg::word_t mem_addr,
  input  cpu_pkg::word_t mem_wdata,
  output logic           mem_done,
  output cpu_pkg::word_t mem_rdata,
  output logic [7:0]     uo_out,
  output logic [7:0]     uio_out,
  output logic [7:0]     uio_oe,
  input  logic [7:0]     uio_in
);
  import cpu_pkg::*;
  import bus_pkg::*;

  bus_phase_t phase;
  logic       take_req;
  logic       active_q;
  word_t      addr_q;
  word_t      data_q;
  word_t      rdata_sh;
  logic       out_phase;
  logic       in_phase;
  logic [1:0] lane;

  // A request still held in the done cycle was already served
  assign take_req = mem_req && !mem_done;

  assign out_phase = phase inside {PH_OUT0, PH_OUT1, PH_OUT2, PH_OUT3};
  assign in_phase  = phase inside {PH_IN0, PH_IN1, PH_IN2, PH_IN3};
  assign lane      = 2'(phase - PH_OUT0);  // Byte index during output phases

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase    <= PH_LATCH;
      active_q <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      if (phase == bus_phase_t'(FRAME_LEN - 1)) begin
        phase <= PH_LATCH;
      end else begin
        phase <= bus_phase_t'(phase + 1'b1);
      end
      if (phase == PH_LATCH) begin
        active_q <= take_req;
      end
      mem_done <= (phase == PH_IN3) && active_q;  // Lands with the return to PH_LATCH
    end
  end

  always_ff @(posedge clk) begin
    if (phase == PH_LATCH) begin
      addr_q                <= mem_addr;
      addr_q[REQ_VALID_BIT] <= take_req;
      addr_q[REQ_WRITE_BIT] <= take_req && mem_write;
      data_q                <= mem_wdata;
    end
    if (in_phase) begin
      rdata_sh <= {uio_in, rdata_sh[WORD_W-1:8]};  // Low byte arrives first
    end
  end

  assign mem_rdata = rdata_sh;

  assign uo_out  = out_phase ? addr_q[lane*8 +: 8] : 8'h00;
  assign uio_out = out_phase ? data_q[lane*8 +: 8] : 8'h00;
  assign uio_oe  = out_phase ? 8'hFF : 8'h00;  // Pins released for the read bytes

endmodule

//--- rtl/tt_cpu_top.sv
// Chip top level joining the CPU core to the byte-serial pin bus
`timescale 1ns/1ns

module tt_cpu_top #(
  parameter cpu_pkg::word_t RESET_PC = '0
) (
  input  logic [7:0] ui_in,
  output logic [7:0] uo_out,
  input  logic [7:0] uio_in,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe,
  input  logic       ena,
  input  logic       clk,
  input  logic       arst_n
);
  import cpu_pkg::*;

  logic  mem_req;
  logic  mem_write;
  word_t mem_addr;
  word_t mem_wdata;
  logic  mem_done;
  word_t mem_rdata;

  cpu_core #(
    .RESET_PC (RESET_PC)
  ) u_core (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_done  (mem_done),
    .mem_rdata (mem_rdata)
  );

  byte_bus_handler u_bus (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_done  (mem_done),
    .mem_rdata (mem_rdata),
    .uo_out    (uo_out),
    .uio_out   (uio_out),
    .uio_oe    (uio_oe),
    .uio_in    (uio_in)
  );

endmodule

//--- sim/tt_cpu_assertions.sv
// Bus handler checks on pin drive, the done pulse and the frame wrap
`timescale 1ns/1ns

module tt_cpu_assertions (
  input logic                clk,
  input logic                arst_n,
  input bus_pkg::bus_phase_t phase,
  input logic                mem_req,
  input logic                mem_done,
  input logic [7:0]          uio_oe
);
  import bus_pkg::*;

  localparam int WRAP_GAP = FRAME_LEN - 1;  // Phases between two latch phases

  int unsigned fail_count = 0;

  // Released in the latch phase, driven for four bytes, released for four
  a_oe_drive_window: assert property (@(posedge clk) disable iff (!arst_n)
    (phase == PH_LATCH) |-> (uio_oe == 8'h00) ##1 (uio_oe == 8'hFF) [*4]
                            ##1 (uio_oe == 8'h00) [*4])
    else begin
      $error("uio_oe is %h outside its drive window", uio_oe);
      fail_count++;
    end

  a_done_after_frame: assert property (@(posedge clk) disable iff (!arst_n)
    mem_done |-> (phase == PH_LATCH) &&
                 $past((phase == PH_LATCH) && mem_req, FRAME_LEN))
    else begin
      $error("mem_done without a request latched one frame earlier");
      fail_count++;
    end

  a_done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    mem_done |=> !mem_done)
    else begin
      $error("mem_done held longer than one cycle");
      fail_count++;
    end

  a_frame_wrap: assert property (@(posedge clk) disable iff (!arst_n)
    (phase == PH_LATCH) |=> (phase != PH_LATCH) [*WRAP_GAP] ##1 (phase == PH_LATCH))
    else begin
      $error("Frame did not wrap after %0d cycles", FRAME_LEN);
      fail_count++;
    end

endmodule

bind byte_bus_handler tt_cpu_assertions u_bus_assert (
  .clk      (clk),
  .arst_n   (arst_n),
  .phase    (phase),
  .mem_req  (mem_req),
  .mem_done (mem_done),
  .uio_oe   (uio_oe)
);

//--- sim/tb_tt_cpu.sv
// Testbench for the byte-bus CPU chip, with a pin-level memory model and an ISA reference
`timescale 1ns/1ns

module tb_tt_cpu;
  import cpu_pkg::*;
  import bus_pkg::*;

  localparam word_t RESET_PC       = 32'h0000_0000;
  localparam int    MEM_WORDS      = 256;
  localparam int    TIMEOUT_CYCLES = 4000;  // 40 instr x 2 frames x 18 cycles, plus margin
  localparam int    KIND_FETCH     = 0;
  localparam int    KIND_LOAD      = 1;
  localparam int    KIND_STORE     = 2;

  logic        clk;
  logic        arst_n;
  logic        ena;
  logic [7:0]  ui_in;
  logic [7:0]  uio_in;
  logic [7:0]  uo_out;
  logic [7:0]  uio_out;
  logic [7:0]  uio_oe;

  word_t       mem     [MEM_WORDS];  // Live memory behind the pins
  word_t       ref_mem [MEM_WORDS];  // Image the reference run ends with
  int          exp_kind [$];
  logic [15:0] exp_addr [$];
  word_t       exp_data [$];
  word_t       obs_addr [$];         // Every frame seen on the pins, stores included
  word_t       obs_wdata [$];
  word_t       obs_rdata [$];
  int          ph;                   // Phase count kept by the memory model
  int          cycle_count;
  word_t       lcg_state;

  tt_cpu_top #(
    .RESET_PC (RESET_PC)
  ) DUT (
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena),
    .clk     (clk),
    .arst_n  (arst_n)
  );

  function automatic word_t lcg_next(input word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t encode(input opcode_t op, input int rd, input int rs1,
                                   input int rs2, input int imm);
    return {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000, 16'(imm)};
  endfunction

  function automatic void expect_frame(input int kind, input word_t addr, input word_t data);
    exp_kind.push_back(kind);
    exp_addr.push_back(addr[17:2]);  // Bus carries word indices
    exp_data.push_back(data);
  endfunction

  // Executes the program on a copy of memory and lists every bus frame it needs
  function automatic void run_reference();
    word_t   regs [NUM_REGS];
    word_t   pc;
    word_t   ir;
    word_t   a;
    word_t   b;
    word_t   imm;
    word_t   ea;
    word_t   res;
    word_t   next_pc;
    opcode_t op;
    logic    wb;
    logic    halted;
    int      steps;
    for (int i = 0; i < NUM_REGS; i++) begin
      regs[i] = '0;
    end
    ref_mem = mem;
    pc      = RESET_PC;
    halted  = 1'b0;
    steps   = 0;
    while (!halted && (steps < 200)) begin
      ir = ref_mem[pc[9:2]];
      expect_frame(KIND_FETCH, pc, ir);
      op      = opcode_t'(ir[31:28]);
      a       = regs[ir[24:22]];
      b       = regs[ir[21:19]];
      imm     = {{16{ir[15]}}, ir[15:0]};
      next_pc = pc + 32'd4;
      wb      = 1'b1;
      res     = '0;
      case (op)
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_OR:   res = a | b;
        OP_XOR:  res = a ^ b;
        OP_ADDI: res = a + imm;
        OP_LUI:  res = {ir[15:0], 16'h0000};
        OP_LW: begin
          ea  = a + imm;
          res = ref_mem[ea[9:2]];
          expect_frame(KIND_LOAD, ea, res);
        end
        OP_SW: begin
          ea = a + imm;
          ref_mem[ea[9:2]] = b;
          expect_frame(KIND_STORE, ea, b);
          wb = 1'b0;
        end
        OP_BEQ: begin
          wb = 1'b0;
          if (a == b) next_pc = pc + 32'd4 + (imm << 2);  // Offset counts words
        end
        OP_JMP: begin
          wb      = 1'b0;
          next_pc = {14'b0, ir[15:0], 2'b00};
        end
        default: begin
          wb     = 1'b0;
          halted = 1'b1;  // HALT
        end
      endcase
      if (wb && (ir[27:25] != 3'd0)) regs[ir[27:25]] = res;  // r0 stays zero
      pc = next_pc;
      steps++;
    end
  endfunction

  task automatic load_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'h5A5A_0000 ^ (i * 32'h9E37_79B1);  // Fill differs in every address bit
    end
    lcg_state = 32'ha3d7;
    for (int i = 128; i < 136; i++) begin  // Data block at byte 0x200
      lcg_state = lcg_next(lcg_state);
      mem[i]    = lcg_state;
    end
    mem[0]  = encode(OP_LW,   1, 0, 0, 'h200);
    mem[1]  = encode(OP_LW,   2, 0, 0, 'h204);
    mem[2]  = encode(OP_SW,   0, 0, 1, 'h300);
    mem[3]  = encode(OP_SW,   0, 0, 2, 'h304);
    mem[4]  = encode(OP_ADD,  3, 1, 2, 0);
    mem[5]  = encode(OP_SW,   0, 0, 3, 'h308);
    mem[6]  = encode(OP_SUB,  4, 1, 2, 0);
    mem[7]  = encode(OP_SW,   0, 0, 4, 'h30C);
    mem[8]  = encode(OP_AND,  5, 1, 2, 0);
    mem[9]  = encode(OP_SW,   0, 0, 5, 'h310);
    mem[10] = encode(OP_OR,   6, 1, 2, 0);
    mem[11] = encode(OP_SW,   0, 0, 6, 'h314);
    mem[12] = encode(OP_XOR,  7, 1, 2, 0);
    mem[13] = encode(OP_SW,   0, 0, 7, 'h318);
    mem[14] = encode(OP_ADDI, 3, 1, 0, -5);
    mem[15] = encode(OP_SW,   0, 0, 3, 'h31C);
    mem[16] = encode(OP_LUI,  4, 0, 0, 'hBEEF);
    mem[17] = encode(OP_ADDI, 4, 4, 0, 'h1234);
    mem[18] = encode(OP_SW,   0, 0, 4, 'h320);
    mem[19] = encode(OP_ADDI, 0, 1, 0, 7);      // Lost in r0
    mem[20] = encode(OP_SW,   0, 0, 0, 'h324);
    mem[21] = encode(OP_BEQ,  0, 1, 2, 5);      // Not taken
    mem[22] = encode(OP_ADDI, 5, 0, 0, 'h300);
    mem[23] = encode(OP_LW,   6, 0, 0, 'h208);
    mem[24] = encode(OP_SW,   0, 5, 6, 'h28);
    mem[25] = encode(OP_BEQ,  0, 6, 6, 2);      // Taken, lands on 28
    mem[26] = encode(OP_SW,   0, 0, 1, 'h32C);
    mem[27] = encode(OP_SW,   0, 0, 2, 'h330);
    mem[28] = encode(OP_JMP,  0, 0, 0, 32);
    mem[29] = encode(OP_SW,   0, 0, 3, 'h334);
    mem[30] = encode(OP_SW,   0, 0, 4, 'h338);
    mem[31] = encode(OP_HALT, 0, 0, 0, 0);
    mem[32] = encode(OP_LW,   7, 0, 0, 'h20C);
    mem[33] = encode(OP_SUB,  7, 7, 1, 0);
    mem[34] = encode(OP_ADDI, 5, 5, 0, 'h40);
    mem[35] = encode(OP_SW,   0, 5, 7, -4);     // Negative offset, byte 0x33C
    mem[36] = encode(OP_LW,   3, 0, 0, 'h328);
    mem[37] = encode(OP_SW,   0, 0, 3, 'h330);
    mem[38] = encode(OP_HALT, 0, 0, 0, 0);
    mem[39] = encode(OP_SW,   0, 0, 1, 'h334);
  endtask

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flags(input string name, input logic got_v, input logic got_w,
                             input logic exp_v, input logic exp_w);
    if ({got_v, got_w} !== {exp_v, exp_w}) begin
      $display("[FAIL] t=%0t %s: got %b%b, expected %b%b", $time, name, got_v, got_w,
               exp_v, exp_w);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_frame(input word_t addr, input word_t wdata, input word_t rdata);
    int    kind;
    string tag;
    if (!addr[REQ_VALID_BIT]) begin
      check_flags("idle frame flags", addr[REQ_VALID_BIT], addr[REQ_WRITE_BIT], 1'b0, 1'b0);
    end else if (exp_kind.size() == 0) begin
      $display("Bus request for word %h appeared after the program halted", addr[15:0]);
      abort_run();
    end else begin
      kind = exp_kind.pop_front();
      case (kind)
        KIND_FETCH: tag = "fetch";
        KIND_LOAD:  tag = "load";
        default:    tag = "store";
      endcase
      check_flags({tag, " flags"}, addr[REQ_VALID_BIT], addr[REQ_WRITE_BIT], 1'b1,
                  kind == KIND_STORE);
      check_addr({tag, " address"}, addr[15:0], exp_addr.pop_front());
      if (kind == KIND_STORE) begin
        check_word("store data", wdata, exp_data.pop_front());
      end else begin
        check_word({tag, " read data"}, rdata, exp_data.pop_front());
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Memory model on the pins, one step per clock a little after the edge
  initial begin : pin_memory
    word_t f_addr;
    word_t f_wdata;
    word_t f_rdata;
    ph      = 0;
    f_addr  = '0;
    f_wdata = '0;
    f_rdata = '0;
    wait (arst_n === 1'b1);
    forever begin
      @(posedge clk);
      #1;
      ph = (ph == FRAME_LEN - 1) ? 0 : ph + 1;
      if ((ph >= 1) && (ph <= 4)) begin
        f_addr[(ph-1)*8 +: 8]  = uo_out;
        f_wdata[(ph-1)*8 +: 8] = uio_out;
      end
      if (ph == 5) begin
        if (f_addr[REQ_VALID_BIT] && f_addr[REQ_WRITE_BIT]) mem[f_addr[7:0]] = f_wdata;
        f_rdata = mem[f_addr[7:0]];
        obs_addr.push_back(f_addr);
        obs_wdata.push_back(f_wdata);
        obs_rdata.push_back(f_rdata);
      end
      uio_in = (ph >= 5) ? f_rdata[(ph-5)*8 +: 8] : 8'h00;  // Low byte first
    end
  end

  initial begin : compare_frames
    logic out_ph;
    wait (arst_n === 1'b1);
    forever begin
      @(posedge clk);
      #2;
      if (DUT.u_bus.u_bus_assert.fail_count != 0) begin
        $display("A bus handler assertion failed");
        abort_run();
      end
      out_ph = (ph >= 1) && (ph <= 4);
      check_byte("uio_oe", uio_oe, out_ph ? 8'hFF : 8'h00);
      if (!out_ph) begin
        check_byte("uo_out", uo_out, 8'h00);
        check_byte("uio_out", uio_out, 8'h00);
      end
      while (obs_addr.size() > 0) begin
        compare_frame(obs_addr.pop_front(), obs_wdata.pop_front(), obs_rdata.pop_front());
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles, the program never ran to its end", cycle_count);
        abort_run();
      end
    end
  end

  initial begin
    arst_n = 1'b0;
    ena    = 1'b1;
    ui_in  = 8'h00;
    uio_in = 8'h00;
    load_memory();
    run_reference();
    repeat (2) @(posedge clk);
    #1;
    check_byte("uo_out", uo_out, 8'h00);
    check_byte("uio_out", uio_out, 8'h00);
    check_byte("uio_oe", uio_oe, 8'h00);
    arst_n = 1'b1;
    while (exp_kind.size() != 0) @(posedge clk);
    repeat (6 * FRAME_LEN) @(posedge clk);  // Frames after HALT must stay idle
    #3;
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_word($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
    end
    if (DUT.u_bus.u_bus_assert.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Bus handler assertions failed %0d times", DUT.u_bus.u_bus_assert.fail_count);
      $display("Checks failed");
      $fatal(1);
    end
  end

endmodule

//--- project.f
rtl/cpu_pkg.sv
rtl/bus_pkg.sv
rtl/cpu_alu.sv
rtl/cpu_regfile.sv
rtl/cpu_core.sv
rtl/byte_bus_handler.sv
rtl/tt_cpu_top.sv
sim/tt_cpu_assertions.sv
sim/tb_tt_cpu.sv

//--- Bender.yml
package:
  name: tt_cpu

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/bus_pkg.sv
      - rtl/cpu_alu.sv
      - rtl/cpu_regfile.sv
      - rtl/cpu_core.sv
      - rtl/byte_bus_handler.sv
      - rtl/tt_cpu_top.sv
  - target: simulation
    files:
      - sim/tt_cpu_assertions.sv
      - sim/tb_tt_cpu.sv
